// File: src/videoTypes.sv
package videoTypes;

    // lcd register addresses
    localparam logic [15:0] LCDC_ADDR = 16'hff40;
    localparam logic [15:0] SCY_ADDR = 16'hff42;
    localparam logic [15:0] SCX_ADDR = 16'hff43;
    localparam logic [15:0] BGP_ADDR = 16'hff47;

    // video ram regions as seen from the cpu
    localparam logic [15:0] TILE_ADDR = 16'h8000;
    localparam logic [15:0] MAP0_ADDR = 16'h9800;
    localparam logic [15:0] MAP1_ADDR = 16'h9c00;
    localparam int TILE_BYTES = 256;
    localparam int MAP_BYTES = 64;

    // offsets into the combined store
    localparam logic [8:0] TILE_BASE = 9'd0;
    localparam logic [8:0] MAP0_BASE = 9'd256;
    localparam logic [8:0] MAP1_BASE = 9'd320;
    localparam int VRAM_BYTES = TILE_BYTES + 2 * MAP_BYTES;

    localparam int TILE_SIZE = 8;
    localparam int MAP_TILES = 8;
    // background is 64x64 and wraps
    localparam int BG_BITS = $clog2(TILE_SIZE * MAP_TILES);

    localparam int LCD_WIDTH = 32;
    localparam int LCD_LINES = 16;
    localparam int X_BITS = $clog2(LCD_WIDTH);
    localparam int LINE_BITS = $clog2(LCD_LINES);

    localparam int PIXEL_CREDITS = 4;
    localparam int CREDIT_BITS = $clog2(PIXEL_CREDITS + 1);

    typedef struct packed {
        logic write;
        logic read;
        logic [15:0] addr;
        logic [7:0] data;
    } BusReq;

    typedef struct packed {
        logic valid;
        logic [7:0] data;
    } BusRsp;

    typedef struct packed {
        logic write;
        logic read;
        logic [8:0] offset;
        logic [7:0] data;
    } VramReq;

    typedef struct packed {
        logic read;
        logic [8:0] offset;
    } RenderReq;

    typedef struct packed {
        logic [X_BITS-1:0] x;
        logic [LINE_BITS-1:0] line;
        logic [1:0] shade;
    } Pixel;

    // lcdc layout, bit 7 down to bit 0
    typedef struct packed {
        logic displayEnable;
        logic [2:0] reservedHigh;
        logic tileMapSelect;
        logic [2:0] reservedLow;
    } LcdControl;

    typedef enum logic [2:0] {
        idle,
        fetchMap,
        fetchLow,
        fetchHigh,
        emit,
        finish
    } RenderState;

endpackage

// File: src/lcdControlBus.sv
`timescale 1ns/1ps

module lcdControlBus (
    input logic db,
    input logic reset,
    input videoTypes::BusReq bus,
    output videoTypes::BusRsp busRsp,
    output videoTypes::VramReq vramReq,
    input logic [7:0] ramData,
    output videoTypes::LcdControl control,
    output logic [7:0] scrollX,
    output logic [7:0] scrollY,
    output logic [7:0] palette
);

    logic inTiles;
    logic inMap0;
    logic inMap1;
    logic inRam;
    logic [8:0] ramOffset;

    // read response bookkeeping, one cycle deep
    logic rspValid;
    logic rspFromRam;
    logic [7:0] rspHeld;

    always_comb begin
        inTiles = (bus.addr >= videoTypes::TILE_ADDR) &&
                  (bus.addr < videoTypes::TILE_ADDR + videoTypes::TILE_BYTES);
        inMap0 = (bus.addr >= videoTypes::MAP0_ADDR) &&
                 (bus.addr < videoTypes::MAP0_ADDR + videoTypes::MAP_BYTES);
        inMap1 = (bus.addr >= videoTypes::MAP1_ADDR) &&
                 (bus.addr < videoTypes::MAP1_ADDR + videoTypes::MAP_BYTES);
        inRam = inTiles || inMap0 || inMap1;

        // fold the three regions into one 384 byte store
        if (inMap1) begin
            ramOffset = 9'(bus.addr - videoTypes::MAP1_ADDR) + videoTypes::MAP1_BASE;
        end else if (inMap0) begin
            ramOffset = 9'(bus.addr - videoTypes::MAP0_ADDR) + videoTypes::MAP0_BASE;
        end else begin
            ramOffset = 9'(bus.addr - videoTypes::TILE_ADDR) + videoTypes::TILE_BASE;
        end
    end

    always_comb begin
        vramReq.write = bus.write && inRam;
        vramReq.read = bus.read && inRam;
        vramReq.offset = ramOffset;
        vramReq.data = bus.data;
    end

    // register file
    always_ff @(posedge db) begin
        if (reset) begin
            control <= '0;
            scrollX <= '0;
            scrollY <= '0;
            palette <= '0;
        end else if (bus.write) begin
            case (bus.addr)
                videoTypes::LCDC_ADDR: control <= videoTypes::LcdControl'(bus.data);
                videoTypes::SCY_ADDR: scrollY <= bus.data;
                videoTypes::SCX_ADDR: scrollX <= bus.data;
                videoTypes::BGP_ADDR: palette <= bus.data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge db) begin
        if (reset) begin
            rspValid <= 1'b0;
            rspFromRam <= 1'b0;
            rspHeld <= '0;
        end else begin
            rspValid <= bus.read;
            rspFromRam <= bus.read && inRam;
            if (bus.read) begin
                case (bus.addr)
                    videoTypes::LCDC_ADDR: rspHeld <= control;
                    videoTypes::SCY_ADDR: rspHeld <= scrollY;
                    videoTypes::SCX_ADDR: rspHeld <= scrollX;
                    videoTypes::BGP_ADDR: rspHeld <= palette;
                    // unmapped reads float high
                    default: rspHeld <= 8'hff;
                endcase
            end
        end
    end

    // ram data arrives in the same cycle as the response
    always_comb begin
        busRsp.valid = rspValid;
        busRsp.data = rspFromRam ? ramData : rspHeld;
    end

    noReadWriteOverlap: assert property (
        @(posedge db) disable iff (reset) !(bus.read && bus.write)
    ) else $error("bus read and write high together");

endmodule

// File: src/videoRam.sv
`timescale 1ns/1ps

module videoRam (
    input logic db,
    input videoTypes::VramReq vramReq,
    output logic [7:0] ramData,
    input videoTypes::RenderReq renderReq,
    output logic [7:0] renderData
);

    // tiles, then map 0, then map 1
    logic [7:0] mem [videoTypes::VRAM_BYTES];

    // cpu side port
    always_ff @(posedge db) begin
        if (vramReq.write) begin
            mem[vramReq.offset] <= vramReq.data;
        end
        if (vramReq.read) begin
            ramData <= mem[vramReq.offset];
        end
    end

    // renderer port, read only
    // holds its last value while no read is issued
    always_ff @(posedge db) begin
        if (renderReq.read) begin
            renderData <= mem[renderReq.offset];
        end
    end

    busOffsetInRange: assert property (
        @(posedge db) (vramReq.read || vramReq.write) |->
            (vramReq.offset < videoTypes::VRAM_BYTES)
    ) else $error("bus access past end of video ram: %h", vramReq.offset);

    renderOffsetInRange: assert property (
        @(posedge db) renderReq.read |->
            (renderReq.offset < videoTypes::VRAM_BYTES)
    ) else $error("render read past end of video ram: %h", renderReq.offset);

endmodule

// File: src/lineRenderer.sv
`timescale 1ns/1ps

module lineRenderer (
    input logic db,
    input logic reset,
    input logic drawLine,
    input videoTypes::LcdControl control,
    input logic [7:0] scrollX,
    input logic [7:0] scrollY,
    input logic [7:0] palette,
    output videoTypes::RenderReq renderReq,
    input logic [7:0] renderData,
    output videoTypes::Pixel pixel,
    output logic pixelValid,
    input logic creditReturn,
    output logic lineDone,
    output logic frameDone
);

    videoTypes::RenderState state;
    videoTypes::RenderState nextState;

    logic [videoTypes::LINE_BITS-1:0] currentLine;
    logic [videoTypes::X_BITS-1:0] xPos;
    logic [videoTypes::CREDIT_BITS-1:0] creditCount;

    // background coordinates, wrap at 64
    logic [videoTypes::BG_BITS-1:0] bgX;
    logic [videoTypes::BG_BITS-1:0] bgY;
    logic [3:0] tileNum;
    logic [7:0] lowByte;

    logic startLine;
    logic sendPixel;
    logic tileEnd;
    logic lastPixel;
    logic [2:0] bitSel;
    logic [1:0] colour;
    logic [1:0] shade;
    logic [8:0] mapBase;

    assign startLine = (state == videoTypes::idle) && drawLine && control.displayEnable;
    assign sendPixel = (state == videoTypes::emit) && (creditCount != '0);
    assign tileEnd = bgX[2:0] == 3'(videoTypes::TILE_SIZE - 1);
    assign lastPixel = xPos == videoTypes::X_BITS'(videoTypes::LCD_WIDTH - 1);
    assign mapBase = control.tileMapSelect ? videoTypes::MAP1_BASE : videoTypes::MAP0_BASE;

    // in emit the high row byte is still sitting on renderData
    always_comb begin
        bitSel = 3'd7 - bgX[2:0];
        colour = {renderData[bitSel], lowByte[bitSel]};
        shade = palette[{colour, 1'b0} +: 2];
    end

    always_comb begin
        renderReq.read = 1'b0;
        renderReq.offset = '0;
        unique case (state)
            videoTypes::fetchMap: begin
                renderReq.read = 1'b1;
                renderReq.offset = mapBase +
                    9'(bgY[5:3] * videoTypes::MAP_TILES + bgX[5:3]);
            end
            videoTypes::fetchLow: begin
                // renderData holds the map entry here
                renderReq.read = 1'b1;
                renderReq.offset = {1'b0, renderData[3:0], bgY[2:0], 1'b0};
            end
            videoTypes::fetchHigh: begin
                renderReq.read = 1'b1;
                renderReq.offset = {1'b0, tileNum, bgY[2:0], 1'b1};
            end
            default: ;
        endcase
    end

    always_comb begin
        nextState = state;
        unique case (state)
            videoTypes::idle: begin
                if (startLine) begin
                    nextState = videoTypes::fetchMap;
                end
            end
            videoTypes::fetchMap: nextState = videoTypes::fetchLow;
            videoTypes::fetchLow: nextState = videoTypes::fetchHigh;
            videoTypes::fetchHigh: nextState = videoTypes::emit;
            videoTypes::emit: begin
                // without credits just sit here
                if (sendPixel && lastPixel) begin
                    nextState = videoTypes::finish;
                end else if (sendPixel && tileEnd) begin
                    nextState = videoTypes::fetchMap;
                end
            end
            videoTypes::finish: nextState = videoTypes::idle;
            default: nextState = videoTypes::idle;
        endcase
    end

    always_ff @(posedge db) begin
        if (reset) begin
            state <= videoTypes::idle;
            currentLine <= '0;
            xPos <= '0;
            creditCount <= videoTypes::CREDIT_BITS'(videoTypes::PIXEL_CREDITS);
            pixel <= '0;
            pixelValid <= 1'b0;
            lineDone <= 1'b0;
            frameDone <= 1'b0;
        end else begin
            state <= nextState;
            pixelValid <= sendPixel;
            lineDone <= 1'b0;
            frameDone <= 1'b0;

            if (sendPixel && !creditReturn) begin
                creditCount <= creditCount - 1'b1;
            end else if (!sendPixel && creditReturn) begin
                creditCount <= creditCount + 1'b1;
            end

            if (startLine) begin
                xPos <= '0;
            end
            if (sendPixel) begin
                pixel.x <= xPos;
                pixel.line <= currentLine;
                pixel.shade <= shade;
                xPos <= xPos + 1'b1;
            end

            if (state == videoTypes::finish) begin
                lineDone <= 1'b1;
                frameDone <= currentLine == videoTypes::LINE_BITS'(videoTypes::LCD_LINES - 1);
                currentLine <= currentLine + 1'b1;
            end
        end
    end

    // fetch datapath
    always_ff @(posedge db) begin
        if (startLine) begin
            bgX <= scrollX[videoTypes::BG_BITS-1:0];
            bgY <= {2'b00, currentLine} + scrollY[videoTypes::BG_BITS-1:0];
        end
        if (sendPixel) begin
            bgX <= bgX + 1'b1;
        end
        if (state == videoTypes::fetchLow) begin
            tileNum <= renderData[3:0];
        end
        if (state == videoTypes::fetchHigh) begin
            lowByte <= renderData;
        end
    end

    // sink must not hand back more than it was granted
    creditsBounded: assert property (
        @(posedge db) disable iff (reset) creditCount <= videoTypes::PIXEL_CREDITS
    ) else $error("credit count overflow: %0d", creditCount);

    noPixelWithoutCredit: assert property (
        @(posedge db) disable iff (reset) pixelValid |-> ($past(creditCount) != '0)
    ) else $error("pixel sent with zero credits");

endmodule

// File: src/whizGraphics.sv
`timescale 1ns/1ps

module whizGraphics (
    input logic db,
    input logic reset,
    input videoTypes::BusReq bus,
    output videoTypes::BusRsp busRsp,
    input logic drawLine,
    output videoTypes::Pixel pixel,
    output logic pixelValid,
    input logic creditReturn,
    output logic lineDone,
    output logic frameDone
);

    videoTypes::VramReq vramReq;
    videoTypes::RenderReq renderReq;
    videoTypes::LcdControl control;
    logic [7:0] ramData;
    logic [7:0] renderData;
    logic [7:0] scrollX;
    logic [7:0] scrollY;
    logic [7:0] palette;

    lcdControlBus controlBus (
        .db(db),
        .reset(reset),
        .bus(bus),
        .busRsp(busRsp),
        .vramReq(vramReq),
        .ramData(ramData),
        .control(control),
        .scrollX(scrollX),
        .scrollY(scrollY),
        .palette(palette)
    );

    videoRam vram (
        .db(db),
        .vramReq(vramReq),
        .ramData(ramData),
        .renderReq(renderReq),
        .renderData(renderData)
    );

    lineRenderer renderer (
        .db(db),
        .reset(reset),
        .drawLine(drawLine),
        .control(control),
        .scrollX(scrollX),
        .scrollY(scrollY),
        .palette(palette),
        .renderReq(renderReq),
        .renderData(renderData),
        .pixel(pixel),
        .pixelValid(pixelValid),
        .creditReturn(creditReturn),
        .lineDone(lineDone),
        .frameDone(frameDone)
    );

endmodule

// File: test/whizGraphicsChecker.sv
`timescale 1ns/1ps

module whizGraphicsChecker (
    input logic db,
    input logic reset,
    input videoTypes::BusReq bus,
    input videoTypes::BusRsp busRsp,
    input videoTypes::Pixel pixel,
    input logic pixelValid,
    input logic creditReturn,
    input logic lineDone,
    input logic frameDone
);

    logic [7:0] readQ[$];
    videoTypes::Pixel pixelQ[$];
    int lineQ[$];

    int readErrors = 0;
    int pixelErrors = 0;
    int otherErrors = 0;
    int readsChecked = 0;
    int pixelsChecked = 0;
    int linesChecked = 0;
    bit readPending;
    int outstanding;

    task automatic expectRead(input logic [7:0] data);
        readQ.push_back(data);
    endtask

    // one hex digit per pixel, x 0 leftmost
    task automatic expectLine(input int lineNo, input logic [127:0] shades);
        videoTypes::Pixel p;
        for (int x = 0; x < videoTypes::LCD_WIDTH; x++) begin
            p.x = 5'(x);
            p.line = 4'(lineNo);
            p.shade = shades[124-4*x +: 2];
            pixelQ.push_back(p);
        end
        lineQ.push_back(lineNo);
    endtask

    task automatic noteProblem(input string msg);
        $display("%0t: %s", $time, msg);
        otherErrors++;
    endtask

    function automatic int errorCount();
        return readErrors + pixelErrors + otherErrors;
    endfunction

    task automatic report();
        if (readQ.size() != 0 || pixelQ.size() != 0 || lineQ.size() != 0) begin
            noteProblem("expected responses never arrived");
        end
        $display("checked %0d reads, %0d pixels, %0d lines; errors read %0d pixel %0d other %0d",
                 readsChecked, pixelsChecked, linesChecked, readErrors, pixelErrors,
                 otherErrors);
    endtask

    always @(posedge db) begin : watch
        logic [7:0] expectedData;
        videoTypes::Pixel expectedPixel;
        int lineNo;
        if (reset) begin
            readPending = 1'b0;
            outstanding = 0;
        end else begin
            if (readPending && !busRsp.valid) begin
                noteProblem("no read response one cycle after the request");
            end
            if (busRsp.valid) begin
                if (readQ.size() == 0) begin
                    noteProblem("read response with no read outstanding");
                end else begin
                    expectedData = readQ.pop_front();
                    readsChecked++;
                    if (busRsp.data !== expectedData) begin
                        $display("Fail busRsp.data: got %h expected %h", busRsp.data,
                                 expectedData);
                        readErrors++;
                    end
                end
            end
            readPending = bus.read;

            if (pixelValid) begin
                if (pixelQ.size() == 0) begin
                    noteProblem("pixel appeared with no line expected");
                end else begin
                    expectedPixel = pixelQ.pop_front();
                    pixelsChecked++;
                    if (pixel !== expectedPixel) begin
                        $display("Fail pixel: got x %h line %h shade %h expected x %h line %h shade %h",
                                 pixel.x, pixel.line, pixel.shade, expectedPixel.x,
                                 expectedPixel.line, expectedPixel.shade);
                        pixelErrors++;
                    end
                end
            end

            // pixels in flight toward the sink
            outstanding = outstanding + int'(pixelValid) - int'(creditReturn);
            if (outstanding > videoTypes::PIXEL_CREDITS) begin
                noteProblem("more pixels outstanding than credits granted");
            end

            if (lineDone) begin
                if (lineQ.size() == 0) begin
                    noteProblem("lineDone with no line drawn");
                end else begin
                    lineNo = lineQ.pop_front();
                    linesChecked++;
                    if (pixelQ.size() != 0) begin
                        noteProblem("lineDone before all pixels of the line");
                    end
                    if (frameDone !== (lineNo == videoTypes::LCD_LINES - 1)) begin
                        $display("Fail frameDone: got %h expected %h", frameDone,
                                 lineNo == videoTypes::LCD_LINES - 1);
                        otherErrors++;
                    end
                end
            end else if (frameDone) begin
                noteProblem("frameDone without lineDone");
            end
        end
    end

endmodule

// File: test/whizGraphicsTb.sv
`timescale 1ns/1ps

module whizGraphicsTb;

    logic db;
    logic reset;
    videoTypes::BusReq bus;
    videoTypes::BusRsp busRsp;
    logic drawLine;
    videoTypes::Pixel pixel;
    logic pixelValid;
    logic creditReturn;
    logic lineDone;
    logic frameDone;

    integer seed = 32'hd402;
    int creditDelay = 0;
    int owed;
    int delayLeft;
    bit timedOut = 1'b0;

    whizGraphics dut_i (
        .db(db),
        .reset(reset),
        .bus(bus),
        .busRsp(busRsp),
        .drawLine(drawLine),
        .pixel(pixel),
        .pixelValid(pixelValid),
        .creditReturn(creditReturn),
        .lineDone(lineDone),
        .frameDone(frameDone)
    );

    whizGraphicsChecker scoreboard (
        .db(db),
        .reset(reset),
        .bus(bus),
        .busRsp(busRsp),
        .pixel(pixel),
        .pixelValid(pixelValid),
        .creditReturn(creditReturn),
        .lineDone(lineDone),
        .frameDone(frameDone)
    );

    initial begin
        db = 1'b0;
    end

    always #4 db = ~db;

    // the sink hands each credit back after a short random delay
    always @(posedge db) begin
        if (reset) begin
            creditReturn <= 1'b0;
            owed = 0;
            delayLeft = 0;
        end else begin
            creditReturn <= 1'b0;
            if (pixelValid) begin
                owed = owed + 1;
            end
            if (owed > 0) begin
                if (delayLeft == 0) begin
                    creditReturn <= 1'b1;
                    owed = owed - 1;
                    delayLeft = ($random(seed) & 3) + creditDelay;
                end else begin
                    delayLeft = delayLeft - 1;
                end
            end
        end
    end

    task automatic reportTimeout(input string what);
        scoreboard.noteProblem({"timeout while waiting for ", what});
        timedOut = 1'b1;
    endtask

    task automatic busWrite(input logic [15:0] addr, input logic [7:0] data);
        @(posedge db);
        bus <= '{write: 1'b1, read: 1'b0, addr: addr, data: data};
        @(posedge db);
        bus <= '0;
    endtask

    task automatic busRead(input logic [15:0] addr, input logic [7:0] expected);
        int cycles;
        scoreboard.expectRead(expected);
        @(posedge db);
        bus <= '{write: 1'b0, read: 1'b1, addr: addr, data: 8'h00};
        @(posedge db);
        bus <= '0;
        cycles = 0;
        do begin
            @(posedge db);
            cycles++;
        end while (!busRsp.valid && cycles < 8);
        if (!busRsp.valid) begin
            reportTimeout("a bus read response");
        end
    endtask

    task automatic renderLine(input int lineNo, input logic [127:0] shades);
        int cycles;
        scoreboard.expectLine(lineNo, shades);
        @(posedge db);
        drawLine <= 1'b1;
        @(posedge db);
        drawLine <= 1'b0;
        cycles = 0;
        do begin
            @(posedge db);
            cycles++;
        end while (!lineDone && cycles < 2000);
        if (!lineDone) begin
            reportTimeout("lineDone");
        end
    endtask

    // display is off, so watch a while for stray pixels
    task automatic ignoredDraw();
        int cycles;
        @(posedge db);
        drawLine <= 1'b1;
        @(posedge db);
        drawLine <= 1'b0;
        for (cycles = 0; cycles < 80; cycles++) begin
            @(posedge db);
        end
    endtask

    initial begin
        int fd;
        int count;
        string text;
        byte cmd;
        logic [15:0] addr;
        logic [127:0] value;
        bus = '0;
        drawLine = 1'b0;
        creditReturn = 1'b0;
        reset = 1'b1;
        repeat (8) @(posedge db);
        reset <= 1'b0;

        fd = $fopen("test/testdata.txt", "r");
        if (fd == 0) begin
            scoreboard.noteProblem("could not open test/testdata.txt");
        end else begin
            while (!$feof(fd) && !timedOut) begin
                text = "";
                count = $fgets(text, fd);
                if (count > 0 && text.len() > 1 && text.getc(0) != "#") begin
                    count = $sscanf(text, "%c %h %h", cmd, addr, value);
                    case (cmd)
                        "W": busWrite(addr, value[7:0]);
                        "R": busRead(addr, value[7:0]);
                        "L": renderLine(int'(addr), value);
                        "D": ignoredDraw();
                        "C": creditDelay = int'(addr);
                        default: scoreboard.noteProblem({"unknown test data line: ", text});
                    endcase
                end
            end
            $fclose(fd);
        end
        repeat (4) @(posedge db);

        scoreboard.report();
        if (scoreboard.errorCount() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: test/testdata.txt
# W addr data | R addr expected | L line shades (32 hex digits, x 0 first)
# D draws with display off | C extra credit delay in cycles
W ff40 80
W ff47 e4
W ff43 00
W ff42 00
R ff40 80
R ff47 e4
R ff43 00
R ff42 00
R ff41 ff
R a000 ff
W 8010 f0
W 8011 cc
W 8012 ff
W 8013 00
W 8020 55
W 8021 0f
W 8022 00
W 8023 00
W 9800 01
W 9801 02
W 9802 02
W 9803 01
W 9807 02
W 9c00 02
W 9c01 01
W 9c02 02
W 9c03 01
R 8011 cc
R 8012 ff
R 8020 55
R 9801 02
R 9807 02
R 9c03 01
L 0 33112200010123230101232333112200
W ff42 ff
W ff47 1b
L 1 00221133323210103232101000221133
W ff47 e4
W ff42 3e
W ff43 3c
L 2 23233311220001012323010123233311
W ff43 00
W ff42 3d
W ff40 88
L 3 01012323331122000101232333112200
W ff40 80
C 6
L 4 11111111000000000000000011111111
C 0
W ff40 00
D
W ff40 80
W ff42 3b
L 5 33112200010123230101232333112200
W ff42 3a
L 6 33112200010123230101232333112200
W ff42 39
L 7 33112200010123230101232333112200
W ff42 38
L 8 33112200010123230101232333112200
W ff42 37
L 9 33112200010123230101232333112200
W ff42 36
L a 33112200010123230101232333112200
W ff42 35
L b 33112200010123230101232333112200
W ff42 34
L c 33112200010123230101232333112200
W ff42 33
L d 33112200010123230101232333112200
W ff42 32
L e 33112200010123230101232333112200
W ff42 31
L f 33112200010123230101232333112200

// File: build.f
src/videoTypes.sv
src/lcdControlBus.sv
src/videoRam.sv
src/lineRenderer.sv
src/whizGraphics.sv
test/whizGraphicsChecker.sv
test/whizGraphicsTb.sv

// File: Makefile
TOP = whizGraphicsTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -o simv
	./obj_dir/simv | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
